// ==== eth_pkg.sv ====
package eth_pkg;

   // host address space
   localparam int addr_w = 13;
   localparam int buf_addr_w = 11;
   localparam int nbytes_w = 16;
   localparam int mac_w = 48;

   // locally administered station address
   localparam logic [mac_w-1:0] default_mac = 48'h02_00_5e_10_20_30;

   // register map
   localparam logic [addr_w-1:0] reg_status = 13'd0;
   localparam logic [addr_w-1:0] reg_control = 13'd1;
   localparam logic [addr_w-1:0] reg_tx_nbytes = 13'd2;
   localparam logic [addr_w-1:0] reg_mac_lo = 13'd3;
   localparam logic [addr_w-1:0] reg_mac_hi = 13'd4;
   localparam logic [addr_w-1:0] reg_dest_lo = 13'd5;
   localparam logic [addr_w-1:0] reg_dest_hi = 13'd6;
   localparam logic [addr_w-1:0] reg_src_lo = 13'd7;
   localparam logic [addr_w-1:0] reg_src_hi = 13'd8;
   localparam logic [addr_w-1:0] reg_rx_nbytes = 13'd9;
   localparam logic [addr_w-1:0] tx_data_base = 13'd2048;
   localparam logic [addr_w-1:0] rx_data_base = 13'd4096;

   // frame layout
   localparam int preamble_nibbles = 16;
   localparam int hdr_bytes = 12;

   // framer states
   localparam logic [2:0] tx_idle = 3'd0;
   localparam logic [2:0] tx_pre = 3'd1;
   localparam logic [2:0] tx_addr = 3'd2;
   localparam logic [2:0] tx_pay = 3'd3;
   localparam logic [2:0] tx_done = 3'd4;

   // parser states
   localparam logic [1:0] rx_sfd = 2'd0;
   localparam logic [1:0] rx_hdr = 2'd1;
   localparam logic [1:0] rx_pay = 2'd2;
   localparam logic [1:0] rx_drop = 2'd3;

   // host write word, decoded by target register
   typedef union packed {
      struct packed {
         logic [29:0] rsvd;
         logic        rx_clear;
         logic        send;
      } ctrl;
      struct packed {
         logic [31-mac_w/2:0] rsvd;
         logic [mac_w/2-1:0]  half;
      } mac;
      struct packed {
         logic [31-nbytes_w:0] rsvd;
         logic [nbytes_w-1:0]  nbytes;
      } count;
   } eth_reg_word_u;

endpackage

// ==== eth_frame_buf.sv ====
`timescale 1ns/1ps

module eth_frame_buf (
   input  logic                         clk,
   input  logic                         we,
   input  logic [eth_pkg::buf_addr_w-1:0] waddr,
   input  logic [7:0]                   wdata,
   input  logic [eth_pkg::buf_addr_w-1:0] raddr,
   output logic [7:0]                   rdata
);
   import eth_pkg::*;

   logic [7:0] mem [0:2**buf_addr_w-1];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // read side is combinational
   assign rdata = mem[raddr];

endmodule

// ==== eth_host_regs.sv ====
`timescale 1ns/1ps

module eth_host_regs (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           sel,
   input  logic                           we,
   input  logic [eth_pkg::addr_w-1:0]     addr,
   input  logic [31:0]                    data_in,
   input  logic                           tx_ready,
   input  logic                           rx_ready,
   input  logic [eth_pkg::nbytes_w-1:0]   rx_nbytes,
   input  logic [eth_pkg::mac_w-1:0]      src_mac,
   input  logic [7:0]                     rx_buf_rdata,
   output logic [31:0]                    data_out,
   output logic                           eth_resetn,
   output logic                           tx_buf_we,
   output logic [eth_pkg::buf_addr_w-1:0] tx_buf_waddr,
   output logic [7:0]                     tx_buf_wdata,
   output logic [eth_pkg::buf_addr_w-1:0] rx_buf_raddr,
   output logic                           tx_send,
   output logic                           rx_clear,
   output logic [eth_pkg::nbytes_w-1:0]   tx_nbytes,
   output logic [eth_pkg::mac_w-1:0]      station_mac,
   output logic [eth_pkg::mac_w-1:0]      dest_mac
);
   import eth_pkg::*;

   eth_reg_word_u wr_word;
   logic          wr;
   logic          in_tx_buf;
   logic          in_rx_buf;
   logic [3:0]    phy_rst_cnt;

   assign wr_word = data_in;
   assign wr = sel && we;

   // buffer windows are aligned to their size
   assign in_tx_buf = (addr[addr_w-1:buf_addr_w] == tx_data_base[addr_w-1:buf_addr_w]);
   assign in_rx_buf = (addr[addr_w-1:buf_addr_w] == rx_data_base[addr_w-1:buf_addr_w]);

   // control strobes last as long as the write cycle
   assign tx_send = wr && (addr == reg_control) && wr_word.ctrl.send;
   assign rx_clear = wr && (addr == reg_control) && wr_word.ctrl.rx_clear;

   assign tx_buf_we = wr && in_tx_buf;
   assign tx_buf_waddr = addr[buf_addr_w-1:0];
   assign tx_buf_wdata = data_in[7:0];
   assign rx_buf_raddr = addr[buf_addr_w-1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         station_mac <= default_mac;
         dest_mac <= default_mac;
         tx_nbytes <= '0;
      end else if (wr) begin
         case (addr)
            reg_tx_nbytes: tx_nbytes <= wr_word.count.nbytes;
            reg_mac_lo: station_mac[mac_w/2-1:0] <= wr_word.mac.half;
            reg_mac_hi: station_mac[mac_w-1:mac_w/2] <= wr_word.mac.half;
            reg_dest_lo: dest_mac[mac_w/2-1:0] <= wr_word.mac.half;
            reg_dest_hi: dest_mac[mac_w-1:mac_w/2] <= wr_word.mac.half;
            default: begin
            end
         endcase
      end
   end

   // read mux returns zero for anything unmapped
   always_comb begin
      data_out = '0;
      case (addr)
         reg_status: data_out = {30'd0, rx_ready, tx_ready};
         reg_tx_nbytes: data_out = {16'd0, tx_nbytes};
         reg_mac_lo: data_out = {8'd0, station_mac[mac_w/2-1:0]};
         reg_mac_hi: data_out = {8'd0, station_mac[mac_w-1:mac_w/2]};
         reg_dest_lo: data_out = {8'd0, dest_mac[mac_w/2-1:0]};
         reg_dest_hi: data_out = {8'd0, dest_mac[mac_w-1:mac_w/2]};
         reg_src_lo: data_out = {8'd0, src_mac[mac_w/2-1:0]};
         reg_src_hi: data_out = {8'd0, src_mac[mac_w-1:mac_w/2]};
         reg_rx_nbytes: data_out = {16'd0, rx_nbytes};
         default: begin
            if (in_rx_buf) begin
               data_out = {24'd0, rx_buf_rdata};
            end
         end
      endcase
   end

   // phy held in reset for 16 cycles
   always_ff @(posedge clk) begin
      if (rst) begin
         phy_rst_cnt <= 4'd0;
         eth_resetn <= 1'b0;
      end else begin
         if (phy_rst_cnt != 4'd15) begin
            phy_rst_cnt <= phy_rst_cnt + 4'd1;
         end
         eth_resetn <= (phy_rst_cnt == 4'd15);
      end
   end

   resetn_stays_high: assert property (@(posedge clk) disable iff (rst)
      eth_resetn |=> eth_resetn);

endmodule

// ==== eth_tx_framer.sv ====
`timescale 1ns/1ps

module eth_tx_framer (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           send,
   input  logic [eth_pkg::nbytes_w-1:0]   nbytes,
   input  logic [eth_pkg::mac_w-1:0]      station_mac,
   input  logic [eth_pkg::mac_w-1:0]      dest_mac,
   input  logic [7:0]                     buf_rdata,
   output logic [eth_pkg::buf_addr_w-1:0] buf_raddr,
   output logic                           tx_en,
   output logic [3:0]                     tx_data,
   output logic                           ready
);
   import eth_pkg::*;

   logic [2:0]           state;
   logic [nbytes_w-1:0]  idx;
   logic [nbytes_w-1:0]  n_q;
   logic                 hi;
   logic [2*mac_w-1:0]   hdr;
   logic [7:0]           hdr_byte;
   logic [7:0]           cur_byte;

   // destination ahead of source with each address msb first
   assign hdr = {dest_mac, station_mac};
   assign hdr_byte = hdr[8*(hdr_bytes-1-idx[3:0]) +: 8];
   assign cur_byte = (state == tx_addr) ? hdr_byte : buf_rdata;

   assign buf_raddr = idx[buf_addr_w-1:0];
   assign ready = (state == tx_idle);
   assign tx_en = (state == tx_pre) || (state == tx_addr) || (state == tx_pay);

   // low nibble goes out first
   always_comb begin
      if (state == tx_pre) begin
         tx_data = (idx == preamble_nibbles - 1) ? 4'hd : 4'h5;
      end else if (tx_en) begin
         tx_data = hi ? cur_byte[7:4] : cur_byte[3:0];
      end else begin
         tx_data = 4'h0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= tx_idle;
         idx <= '0;
         hi <= 1'b0;
      end else begin
         case (state)
            tx_idle: begin
               if (send) begin
                  state <= tx_pre;
                  idx <= '0;
                  hi <= 1'b0;
               end
            end
            tx_pre: begin
               if (idx == preamble_nibbles - 1) begin
                  state <= tx_addr;
                  idx <= '0;
               end else begin
                  idx <= idx + 1'b1;
               end
            end
            tx_addr: begin
               hi <= ~hi;
               if (hi) begin
                  if (idx == hdr_bytes - 1) begin
                     idx <= '0;
                     // empty payload skips straight to the gap
                     state <= (n_q == '0) ? tx_done : tx_pay;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            tx_pay: begin
               hi <= ~hi;
               if (hi) begin
                  if (idx == n_q - 1'b1) begin
                     state <= tx_done;
                  end
                  idx <= idx + 1'b1;
               end
            end
            tx_done: state <= tx_idle;
            default: state <= tx_idle;
         endcase
      end
   end

   // count is frozen for the whole frame
   always_ff @(posedge clk) begin
      if (ready && send) begin
         n_q <= nbytes;
      end
   end

   send_starts_frame: assert property (@(posedge clk) disable iff (rst)
      (ready && send) |=> (tx_en && !ready));

   payload_in_range: assert property (@(posedge clk) disable iff (rst)
      (state == tx_pay) |-> ({5'd0, buf_raddr} < n_q));

endmodule

// ==== eth_rx_parser.sv ====
`timescale 1ns/1ps

module eth_rx_parser (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           rx_dv,
   input  logic [3:0]                     rx_data,
   input  logic                           clear,
   input  logic [eth_pkg::mac_w-1:0]      station_mac,
   output logic                           buf_we,
   output logic [eth_pkg::buf_addr_w-1:0] buf_waddr,
   output logic [7:0]                     buf_wdata,
   output logic [eth_pkg::nbytes_w-1:0]   nbytes,
   output logic [eth_pkg::mac_w-1:0]      src_mac,
   output logic                           ready
);
   import eth_pkg::*;

   logic [1:0]       state;
   // preamble nibbles, then header bytes
   logic [3:0]       cnt;
   logic             hi;
   logic [3:0]       lo_q;
   logic [mac_w-1:0] dest_q;
   logic [7:0]       rx_byte;

   assign rx_byte = {rx_data, lo_q};

   // byte assembly and header capture
   always_ff @(posedge clk) begin
      if (rx_dv && !hi) begin
         lo_q <= rx_data;
      end
      if ((state == rx_hdr) && rx_dv && hi) begin
         if (cnt < hdr_bytes / 2) begin
            dest_q <= {dest_q[mac_w-9:0], rx_byte};
         end else begin
            src_mac <= {src_mac[mac_w-9:0], rx_byte};
         end
      end
      // write lands one cycle after the high nibble
      buf_wdata <= rx_byte;
      buf_waddr <= nbytes[buf_addr_w-1:0];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= rx_sfd;
         cnt <= '0;
         hi <= 1'b0;
         buf_we <= 1'b0;
         nbytes <= '0;
         ready <= 1'b0;
      end else begin
         buf_we <= 1'b0;
         case (state)
            rx_sfd: begin
               hi <= 1'b0;
               if (!rx_dv) begin
                  cnt <= '0;
               end else if (ready) begin
                  // previous frame not yet taken by the host
                  state <= rx_drop;
               end else if (rx_data == 4'hd) begin
                  state <= rx_hdr;
                  cnt <= '0;
               end else if (cnt == preamble_nibbles - 1) begin
                  state <= rx_drop;
               end else begin
                  cnt <= cnt + 4'd1;
               end
            end
            rx_hdr: begin
               if (!rx_dv) begin
                  state <= rx_sfd;
                  cnt <= '0;
               end else begin
                  hi <= ~hi;
                  if (hi) begin
                     cnt <= cnt + 4'd1;
                     if (cnt == hdr_bytes - 1) begin
                        if (dest_q == station_mac) begin
                           state <= rx_pay;
                           nbytes <= '0;
                        end else begin
                           state <= rx_drop;
                        end
                     end
                  end
               end
            end
            rx_pay: begin
               if (!rx_dv) begin
                  state <= rx_sfd;
                  cnt <= '0;
                  if (nbytes != '0) begin
                     ready <= 1'b1;
                  end
               end else begin
                  hi <= ~hi;
                  if (hi) begin
                     buf_we <= 1'b1;
                     nbytes <= nbytes + 1'b1;
                  end
               end
            end
            default: begin
               if (!rx_dv) begin
                  state <= rx_sfd;
                  cnt <= '0;
               end
            end
         endcase
         if (clear) begin
            ready <= 1'b0;
         end
      end
   end

   held_while_ready: assert property (@(posedge clk) disable iff (rst)
      buf_we |-> !ready);

   no_addr_wrap: assert property (@(posedge clk) disable iff (rst)
      buf_we |-> (nbytes <= 2**buf_addr_w));

endmodule

// ==== eth_core.sv ====
`timescale 1ns/1ps

module eth_core (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       sel,
   input  logic                       we,
   input  logic [eth_pkg::addr_w-1:0] addr,
   input  logic [31:0]                data_in,
   output logic [31:0]                data_out,
   output logic                       eth_resetn,
   input  logic [3:0]                 rx_data,
   input  logic                       rx_dv,
   output logic                       tx_en,
   output logic [3:0]                 tx_data
);
   import eth_pkg::*;

   logic                  tx_buf_we;
   logic [buf_addr_w-1:0] tx_buf_waddr;
   logic [7:0]            tx_buf_wdata;
   logic [buf_addr_w-1:0] tx_buf_raddr;
   logic [7:0]            tx_buf_rdata;
   logic                  rx_buf_we;
   logic [buf_addr_w-1:0] rx_buf_waddr;
   logic [7:0]            rx_buf_wdata;
   logic [buf_addr_w-1:0] rx_buf_raddr;
   logic [7:0]            rx_buf_rdata;
   logic                  tx_send;
   logic                  rx_clear;
   logic                  tx_ready;
   logic                  rx_ready;
   logic [nbytes_w-1:0]   tx_nbytes;
   logic [nbytes_w-1:0]   rx_nbytes;
   logic [mac_w-1:0]      station_mac;
   logic [mac_w-1:0]      dest_mac;
   logic [mac_w-1:0]      src_mac;

   eth_host_regs regs (
      .clk(clk), .rst(rst), .sel(sel), .we(we), .addr(addr), .data_in(data_in),
      .tx_ready(tx_ready), .rx_ready(rx_ready), .rx_nbytes(rx_nbytes),
      .src_mac(src_mac), .rx_buf_rdata(rx_buf_rdata),
      .data_out(data_out), .eth_resetn(eth_resetn),
      .tx_buf_we(tx_buf_we), .tx_buf_waddr(tx_buf_waddr), .tx_buf_wdata(tx_buf_wdata),
      .rx_buf_raddr(rx_buf_raddr), .tx_send(tx_send), .rx_clear(rx_clear),
      .tx_nbytes(tx_nbytes), .station_mac(station_mac), .dest_mac(dest_mac)
   );

   eth_frame_buf tx_buf (
      .clk(clk), .we(tx_buf_we), .waddr(tx_buf_waddr), .wdata(tx_buf_wdata),
      .raddr(tx_buf_raddr), .rdata(tx_buf_rdata)
   );

   eth_frame_buf rx_buf (
      .clk(clk), .we(rx_buf_we), .waddr(rx_buf_waddr), .wdata(rx_buf_wdata),
      .raddr(rx_buf_raddr), .rdata(rx_buf_rdata)
   );

   eth_tx_framer tx (
      .clk(clk), .rst(rst), .send(tx_send), .nbytes(tx_nbytes),
      .station_mac(station_mac), .dest_mac(dest_mac), .buf_rdata(tx_buf_rdata),
      .buf_raddr(tx_buf_raddr), .tx_en(tx_en), .tx_data(tx_data), .ready(tx_ready)
   );

   eth_rx_parser rx (
      .clk(clk), .rst(rst), .rx_dv(rx_dv), .rx_data(rx_data), .clear(rx_clear),
      .station_mac(station_mac), .buf_we(rx_buf_we), .buf_waddr(rx_buf_waddr),
      .buf_wdata(rx_buf_wdata), .nbytes(rx_nbytes), .src_mac(src_mac),
      .ready(rx_ready)
   );

endmodule

// ==== tb_eth_core.sv ====
`timescale 1ns/1ps

module tb_eth_core;
   import eth_pkg::*;

   localparam int clk_period = 100;
   localparam int len_a = 20;
   localparam int len_b = 8;
   localparam int len_c = 12;
   // frames sent: tx check, held, filtered, final
   localparam int frame_sum = 4 * 40 + 2 * (len_a + 2 * len_b + len_c);
   localparam int watchdog_cycles = frame_sum * 4 + 2000;
   localparam logic [mac_w-1:0] new_station = 48'h0a_1b_2c_3d_4e_5f;
   localparam logic [mac_w-1:0] other_dest = 48'h12_34_56_78_9a_bc;

   logic              clk;
   logic              rst;
   logic              sel;
   logic              we;
   logic [addr_w-1:0] addr;
   logic [31:0]       data_in;
   logic [31:0]       data_out;
   logic              eth_resetn;
   logic              tx_en;
   logic [3:0]        tx_data;
   int                errors;
   logic [3:0]        nibbles [$];
   logic [7:0]        payload [$];
   logic [7:0]        pay_a [$];
   logic [7:0]        rx_expect [$];

   // tx nibbles looped straight back into rx
   eth_core uut (
      .clk(clk), .rst(rst), .sel(sel), .we(we), .addr(addr), .data_in(data_in),
      .data_out(data_out), .eth_resetn(eth_resetn),
      .rx_data(tx_data), .rx_dv(tx_en), .tx_en(tx_en), .tx_data(tx_data)
   );

   initial clk = 1'b0;
   always #(clk_period / 2) clk = ~clk;

   // capture every nibble on the wire
   always @(negedge clk) begin
      if (tx_en) begin
         nibbles.push_back(tx_data);
      end
   end

   task automatic host_write(input logic [addr_w-1:0] a, input logic [31:0] d);
      @(posedge clk);
      sel <= 1'b1;
      we <= 1'b1;
      addr <= a;
      data_in <= d;
      @(posedge clk);
      sel <= 1'b0;
      we <= 1'b0;
   endtask

   task automatic host_read(input logic [addr_w-1:0] a, output logic [31:0] d);
      @(posedge clk);
      sel <= 1'b1;
      we <= 1'b0;
      addr <= a;
      @(negedge clk);
      d = data_out;
   endtask

   task automatic check_word(input string name, input logic [31:0] want,
                             input logic [31:0] got);
      if (got !== want) begin
         $display("FAILED %s: expected %h, got %h", name, want, got);
         errors++;
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] want,
                             input logic [7:0] got);
      if (got !== want) begin
         $display("FAILED %s: expected %h, got %h", name, want, got);
         errors++;
      end
   endtask

   task automatic check_mac(input string name, input logic [mac_w-1:0] want,
                            input logic [mac_w-1:0] got);
      if (got !== want) begin
         $display("FAILED %s: expected %h, got %h", name, want, got);
         errors++;
      end
   endtask

   // junk in the top byte, the register must drop it
   task automatic write_mac(input logic [addr_w-1:0] lo_addr, input logic [mac_w-1:0] mac);
      eth_reg_word_u w;
      w = '0;
      w.mac.rsvd = 8'ha5;
      w.mac.half = mac[mac_w/2-1:0];
      host_write(lo_addr, w);
      w.mac.half = mac[mac_w-1:mac_w/2];
      host_write(lo_addr + 13'd1, w);
   endtask

   task automatic read_mac(input logic [addr_w-1:0] lo_addr, output logic [mac_w-1:0] mac);
      logic [31:0] lo;
      logic [31:0] hi;
      host_read(lo_addr, lo);
      host_read(lo_addr + 13'd1, hi);
      mac = {hi[mac_w/2-1:0], lo[mac_w/2-1:0]};
   endtask

   task automatic load_payload(input int n);
      eth_reg_word_u w;
      payload.delete();
      for (int i = 0; i < n; i++) begin
         payload.push_back(8'($urandom));
         host_write(tx_data_base + addr_w'(i), {24'd0, payload[i]});
      end
      w = '0;
      w.count.nbytes = nbytes_w'(n);
      host_write(reg_tx_nbytes, w);
   endtask

   task automatic send_and_wait();
      eth_reg_word_u w;
      logic [31:0] status;
      int polls;
      w = '0;
      w.ctrl.send = 1'b1;
      nibbles.delete();
      host_write(reg_control, w);
      polls = 0;
      do begin
         host_read(reg_status, status);
         polls++;
      end while (status[0] !== 1'b1 && polls < 1000);
      if (status[0] !== 1'b1) begin
         $display("tx_ready did not come back after a send");
         errors++;
      end
      repeat (2) @(posedge clk);
   endtask

   // wire bytes rebuilt from nibble pairs, low nibble first
   task automatic check_tx_stream(input logic [mac_w-1:0] dest, input logic [mac_w-1:0] src);
      logic [7:0] want [$];
      string part;
      for (int i = 0; i < 7; i++) begin
         want.push_back(8'h55);
      end
      want.push_back(8'hd5);
      for (int i = 0; i < 6; i++) begin
         want.push_back(dest[mac_w-1-8*i -: 8]);
      end
      for (int i = 0; i < 6; i++) begin
         want.push_back(src[mac_w-1-8*i -: 8]);
      end
      foreach (payload[i]) begin
         want.push_back(payload[i]);
      end
      check_word("tx_frame nibble count", 32'(2 * want.size()), 32'(nibbles.size()));
      if (nibbles.size() == 2 * want.size()) begin
         foreach (want[j]) begin
            part = (j < 8) ? "preamble" : ((j < 20) ? "address" : "payload");
            check_byte($sformatf("tx_frame %s byte %0d", part, j), want[j],
                       {nibbles[2*j+1], nibbles[2*j]});
         end
      end
   endtask

   task automatic check_rx_frame(input string name);
      logic [31:0] w;
      logic [mac_w-1:0] mac;
      host_read(reg_status, w);
      check_word({name, " status"}, 32'h3, w);
      host_read(reg_rx_nbytes, w);
      check_word({name, " rx_nbytes"}, 32'(rx_expect.size()), w);
      read_mac(reg_src_lo, mac);
      check_mac({name, " src"}, new_station, mac);
      foreach (rx_expect[i]) begin
         host_read(rx_data_base + addr_w'(i), w);
         check_byte($sformatf("%s rx byte %0d", name, i), rx_expect[i], w[7:0]);
      end
   endtask

   task automatic test_reset_state();
      logic [31:0] w;
      logic [mac_w-1:0] mac;
      repeat (15) @(posedge clk);
      @(negedge clk);
      check_word("reset_state resetn before 16 cycles", 32'd0, {31'd0, eth_resetn});
      @(posedge clk);
      @(negedge clk);
      check_word("reset_state resetn after 16 cycles", 32'd1, {31'd0, eth_resetn});
      host_read(reg_status, w);
      check_word("reset_state status", 32'h1, w);
      read_mac(reg_dest_lo, mac);
      check_mac("reset_state dest", default_mac, mac);
   endtask

   task automatic test_register_rw();
      logic [31:0] w;
      write_mac(reg_mac_lo, new_station);
      write_mac(reg_dest_lo, other_dest);
      host_read(reg_mac_lo, w);
      check_word("register_rw mac_lo", {8'd0, new_station[23:0]}, w);
      host_read(reg_mac_hi, w);
      check_word("register_rw mac_hi", {8'd0, new_station[47:24]}, w);
      host_read(reg_dest_lo, w);
      check_word("register_rw dest_lo", {8'd0, other_dest[23:0]}, w);
      host_read(reg_dest_hi, w);
      check_word("register_rw dest_hi", {8'd0, other_dest[47:24]}, w);
   endtask

   task automatic test_tx_frame();
      write_mac(reg_dest_lo, new_station);
      load_payload(len_a);
      pay_a = payload;
      send_and_wait();
      check_tx_stream(new_station, new_station);
   endtask

   task automatic test_loopback_rx();
      rx_expect = pay_a;
      check_rx_frame("loopback_rx");
   endtask

   task automatic test_filter_and_hold();
      eth_reg_word_u w;
      logic [31:0] status;
      // rx_ready still set, this frame must be dropped
      load_payload(len_b);
      send_and_wait();
      check_rx_frame("filter_and_hold held");
      w = '0;
      w.ctrl.rx_clear = 1'b1;
      host_write(reg_control, w);
      host_read(reg_status, status);
      check_word("filter_and_hold cleared", 32'h1, status);
      write_mac(reg_dest_lo, other_dest);
      send_and_wait();
      host_read(reg_status, status);
      check_word("filter_and_hold mismatch", 32'h1, status);
      write_mac(reg_dest_lo, new_station);
      load_payload(len_c);
      send_and_wait();
      rx_expect = payload;
      check_rx_frame("filter_and_hold final");
   endtask

   initial begin
      void'($urandom(32'hda6d_9418));
      errors = 0;
      rst = 1'b1;
      sel = 1'b0;
      we = 1'b0;
      addr = '0;
      data_in = '0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      test_reset_state();
      test_register_rw();
      test_tx_frame();
      test_loopback_rx();
      test_filter_and_hold();
      $display("tb_eth_core finished with %0d errors", errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("timeout: run exceeded %0d cycles without finishing", watchdog_cycles);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== all.f ====
eth_pkg.sv
eth_frame_buf.sv
eth_host_regs.sv
eth_tx_framer.sv
eth_rx_parser.sv
eth_core.sv
tb_eth_core.sv

// ==== Makefile ====
VERILATOR = verilator
TOP = tb_eth_core
RTL_TOP = eth_core
FILELIST = all.f
OBJ_DIR = obj_dir
LOG = sim.log
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS = --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failures found" >> $(LOG)
	cat $(LOG)
	! grep -q "Test failures found" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
